//--- filelist.f
source/aluPkg.sv
source/axiPkg.sv
source/aluLane.sv
source/jobDispatch.sv
source/resultCollect.sv
source/axiLiteRegs.sv
source/aluArrayTop.sv
sim/aluArray_sva.sv
sim/aluArrayTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f filelist.f --top-module aluArrayTb -o simAluArray

./obj_dir/simAluArray | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

//--- sim/aluArrayTb.sv
`default_nettype none

module aluArrayTb;
  timeunit 1ns;
  timeprecision 1ps;
  import aluPkg::*;
  import axiPkg::*;

  localparam int HalfJobs = 150;   // 300 jobs over the two random tests
  localparam int PeekJobs = 6;     // more than the four lanes
  localparam int TotalJobs = 2 * HalfJobs + 2 * PeekJobs + 20;
  localparam int ClkNs = 40;

  logic  clk;
  logic  rstN;
  axiAwT aw;
  logic  awready;
  axiWT  w;
  logic  wready;
  axiBT  b;
  logic  bready;
  axiArT ar;
  logic  arready;
  axiRT  r;
  logic  rready;

  integer seed = 32'h3021_9db6;
  int     errors = 0;
  int     checks = 0;
  bit     stallOn = 1'b0;  // random stalls on bready and rready

  aluArrayTop UUT (
    .clk, .rstN, .aw, .awready, .w, .wready, .b, .bready,
    .ar, .arready, .r, .rready
  );

  always #(ClkNs / 2) clk = ~clk;

  task automatic logError(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic checkFlags(input string name, input aluFlagsT got, input aluFlagsT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkResp(input string name, input axiRespE got, input axiRespE exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int startErr);
    if (errors == startErr) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - startErr);
  endtask

  function automatic logic [31:0] slotAddr(input logic [TagW-1:0] tag, input bit flags);
    return SlotBase + 32'(tag) * 32'd8 + (flags ? 32'd4 : 32'd0);
  endfunction

  // reference ALU with carry and overflow only for ADD and SUB
  task automatic modelAlu(input aluOpE op, input logic [31:0] opA, input logic [31:0] opB,
                          output logic [31:0] res, output aluFlagsT flags);
    logic [32:0] wide;
    flags = '{valid: 1'b1, overflow: 1'b0, zero: 1'b0, carryout: 1'b0};
    case (op)
      OpAdd: begin
        wide = {1'b0, opA} + {1'b0, opB};
        res = wide[31:0];
        flags.carryout = wide[32];
        flags.overflow = (opA[31] == opB[31]) && (res[31] != opA[31]);
      end
      OpSub: begin
        res = opA - opB;
        flags.carryout = (opA >= opB);  // carry set when no borrow
        flags.overflow = (opA[31] != opB[31]) && (res[31] != opA[31]);
      end
      OpXor:   res = opA ^ opB;
      OpSlt:   res = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      OpAnd:   res = opA & opB;
      OpNand:  res = ~(opA & opB);
      OpNor:   res = ~(opA | opB);
      default: res = opA | opB;
    endcase
    flags.zero = (res == 32'd0);
  endtask

  task automatic axiWrite(input logic [31:0] target, input logic [31:0] data,
                          input axiRespE expResp);
    axiRespE firstResp;
    bit      seen;
    bit      done;
    seen = 1'b0;
    done = 1'b0;
    firstResp = AxiOkay;
    @(posedge clk);
    aw <= '{addr: target, valid: 1'b1};
    w <= '{data: data, strb: 4'hf, valid: 1'b1};
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    aw.valid <= 1'b0;
    w.valid <= 1'b0;
    while (!done) begin
      bready <= stallOn ? ($random(seed) % 3 != 0) : 1'b1;
      @(negedge clk);
      if (b.valid) begin
        if (seen && b.resp !== firstResp) logError("write response changed while bvalid was held");
        if (awready || wready) logError("AW or W ready while a write response was pending");
        firstResp = b.resp;
        seen = 1'b1;
        done = bready;
      end
      @(posedge clk);
    end
    bready <= 1'b0;
    checkResp($sformatf("bresp at 0x%08h", target), firstResp, expResp);
  endtask

  task automatic axiRead(input logic [31:0] target, output logic [31:0] data,
                         output axiRespE resp);
    bit seen;
    bit done;
    seen = 1'b0;
    done = 1'b0;
    data = '0;
    resp = AxiOkay;
    @(posedge clk);
    ar <= '{addr: target, valid: 1'b1};
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    ar.valid <= 1'b0;
    while (!done) begin
      rready <= stallOn ? ($random(seed) % 3 != 0) : 1'b1;
      @(negedge clk);
      if (r.valid) begin
        if (seen && (r.data !== data || r.resp !== resp)) begin
          logError("read response changed while rvalid was held");
        end
        if (arready) logError("AR ready while a read response was pending");
        data = r.data;
        resp = r.resp;
        seen = 1'b1;
        done = rready;
      end
      @(posedge clk);
    end
    rready <= 1'b0;
  endtask

  task automatic readCheck(input logic [31:0] target, input logic [31:0] expData,
                           input axiRespE expResp);
    logic [31:0] got;
    axiRespE     resp;
    axiRead(target, got, resp);
    checkResp($sformatf("rresp at 0x%08h", target), resp, expResp);
    checkWord($sformatf("rdata at 0x%08h", target), got, expData);
  endtask

  task automatic readSlot(input logic [TagW-1:0] tag, input logic [31:0] expRes,
                          input aluFlagsT expFlags);
    logic [31:0] got;
    axiRespE     resp;
    readCheck(slotAddr(tag, 1'b0), expRes, AxiOkay);
    axiRead(slotAddr(tag, 1'b1), got, resp);
    checkResp($sformatf("rresp slot %0d flags", tag), resp, AxiOkay);
    checkFlags($sformatf("rdata slot %0d flags", tag), aluFlagsT'(got[3:0]), expFlags);
  endtask

  task automatic runJob(input aluOpE op, input logic [31:0] opA, input logic [31:0] opB,
                        input logic [TagW-1:0] tag);
    logic [31:0] cmd;
    logic [31:0] expRes;
    aluFlagsT    expFlags;
    cmd = '0;
    cmd[2:0] = op;
    cmd[11:8] = tag;
    modelAlu(op, opA, opB, expRes, expFlags);
    axiWrite(OperandAAddr, opA, AxiOkay);
    axiWrite(OperandBAddr, opB, AxiOkay);
    axiWrite(CommandAddr, cmd, AxiOkay);
    repeat (3) @(posedge clk);  // fixed latency to the slot
    readSlot(tag, expRes, expFlags);
  endtask

  task automatic runRandomJob();
    aluOpE          op;
    logic [31:0]    opA;
    logic [31:0]    opB;
    logic [TagW-1:0] tag;
    op = aluOpE'(3'($random(seed)));
    opA = $random(seed);
    opB = $random(seed);
    tag = TagW'($random(seed));
    runJob(op, opA, opB, tag);
  endtask

  // relaunch the same job and read its flags on the edge between clear and write
  task automatic peekAfterLaunch(input logic [TagW-1:0] tag);
    aluOpE       op;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] cmd;
    logic [31:0] expRes;
    aluFlagsT    expFlags;
    aluFlagsT    stale;
    op = aluOpE'(3'($random(seed)));
    opA = $random(seed);
    opB = $random(seed);
    runJob(op, opA, opB, tag);  // slot now valid with these flags
    modelAlu(op, opA, opB, expRes, expFlags);
    stale = expFlags;
    stale.valid = 1'b0;
    cmd = '0;
    cmd[2:0] = op;
    cmd[11:8] = tag;
    @(posedge clk);
    aw <= '{addr: CommandAddr, valid: 1'b1};
    w <= '{data: cmd, strb: 4'hf, valid: 1'b1};
    bready <= 1'b1;
    rready <= 1'b1;
    @(posedge clk);  // command accepted on this launch edge
    aw.valid <= 1'b0;
    w.valid <= 1'b0;
    @(negedge clk);
    if (!b.valid) logError("no write response after the command write");
    @(posedge clk);  // B taken and the slot clear lands
    ar <= '{addr: slotAddr(tag, 1'b1), valid: 1'b1};
    @(posedge clk);  // read taken before the lane write
    ar.valid <= 1'b0;
    @(negedge clk);
    if (!r.valid) logError("no read response after the early slot read");
    checkResp($sformatf("rresp slot %0d early", tag), r.resp, AxiOkay);
    checkFlags($sformatf("rdata slot %0d early flags", tag), aluFlagsT'(r.data[3:0]), stale);
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
    repeat (3) @(posedge clk);
    readSlot(tag, expRes, expFlags);
  endtask

  initial begin
    #(TotalJobs * 30 * ClkNs + 100 * ClkNs);
    $display("watchdog expired before the tests finished");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int startErr;
    clk = 1'b0;
    rstN = 1'b0;
    aw = '0;
    w = '0;
    ar = '0;
    bready = 1'b0;
    rready = 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    startErr = errors;
    for (int j = 0; j < HalfJobs; j++) runRandomJob();
    reportTest("random jobs", startErr);

    stallOn = 1'b1;
    startErr = errors;
    for (int j = 0; j < HalfJobs; j++) runRandomJob();
    reportTest("random jobs with B and R stalls", startErr);
    stallOn = 1'b0;

    startErr = errors;
    runJob(OpAdd, 32'h7fff_ffff, 32'h0000_0001, 4'd1);  // overflow
    runJob(OpAdd, 32'hffff_ffff, 32'h0000_0001, 4'd2);  // carry and zero
    runJob(OpSub, 32'h1234_5678, 32'h1234_5678, 4'd3);
    runJob(OpSub, 32'h8000_0000, 32'h0000_0001, 4'd4);
    reportTest("directed flag cases", startErr);

    startErr = errors;
    runJob(OpSlt, 32'h8000_0000, 32'h0000_0001, 4'd5);
    runJob(OpSlt, 32'h0000_0001, 32'h8000_0000, 4'd6);
    runJob(OpSlt, 32'h7fff_ffff, 32'h8000_0000, 4'd7);
    runJob(OpSlt, 32'hffff_ffff, 32'h0000_0000, 4'd8);
    reportTest("SLT signed edges", startErr);

    startErr = errors;
    for (int j = 0; j < PeekJobs; j++) peekAfterLaunch(TagW'(j + 9));
    reportTest("slot valid across launch", startErr);

    startErr = errors;
    axiWrite(OperandAAddr, 32'hcafe_f00d, AxiOkay);
    axiWrite(OperandBAddr, 32'h0bad_beef, AxiOkay);
    axiWrite(32'h0000_000c, 32'h1111_1111, AxiSlvErr);
    axiWrite(32'h0000_003c, 32'h2222_2222, AxiSlvErr);
    axiWrite(slotAddr(4'd0, 1'b0), 32'h3333_3333, AxiSlvErr);  // slots are read only
    readCheck(32'h0000_000c, 32'h0, AxiSlvErr);
    readCheck(CommandAddr, 32'h0, AxiSlvErr);
    readCheck(SlotBase + 32'd128, 32'h0, AxiSlvErr);  // one past the last slot
    readCheck(OperandAAddr, 32'hcafe_f00d, AxiOkay);
    readCheck(OperandBAddr, 32'h0bad_beef, AxiOkay);
    reportTest("unmapped addresses", startErr);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/aluArray_sva.sv
`default_nettype none

module axiRegsSva (
  input logic          clk,
  input logic          rstN,
  input axiPkg::axiAwT aw,
  input logic          awready,
  input axiPkg::axiWT  w,
  input logic          wready,
  input axiPkg::axiBT  b,
  input logic          bready,
  input axiPkg::axiRT  r,
  input logic          rready,
  input logic          launchValid
);
  timeunit 1ns;
  timeprecision 1ps;

  // a response waiting for its ready keeps its payload
  bHeld: assert property (@(posedge clk) disable iff (!rstN)
    b.valid && !bready |=> b.valid && $stable(b.resp))
    else $error("bvalid dropped or bresp changed before bready");

  rHeld: assert property (@(posedge clk) disable iff (!rstN)
    r.valid && !rready |=> r.valid && $stable(r.data) && $stable(r.resp))
    else $error("rvalid dropped or read payload changed before rready");

  launchPulse: assert property (@(posedge clk) disable iff (!rstN)
    launchValid |=> !launchValid)
    else $error("launchValid held for more than one cycle");

  // launch only rides on a completed AW and W handshake
  launchAccepted: assert property (@(posedge clk) disable iff (!rstN)
    launchValid |-> aw.valid && awready && w.valid && wready)
    else $error("launchValid without an accepted write");

endmodule

bind axiLiteRegs axiRegsSva uSva (
  .clk(clk),
  .rstN(rstN),
  .aw(aw),
  .awready(awready),
  .w(w),
  .wready(wready),
  .b(b),
  .bready(bready),
  .r(r),
  .rready(rready),
  .launchValid(launchValid)
);

`default_nettype wire

//--- source/aluArrayTop.sv
`default_nettype none

module aluArrayTop #(
  parameter int NumLanes = 4,
  parameter int NumSlots = aluPkg::DefaultSlots
) (
  input  logic          clk,
  input  logic          rstN,
  input  axiPkg::axiAwT aw,
  output logic          awready,
  input  axiPkg::axiWT  w,
  output logic          wready,
  output axiPkg::axiBT  b,
  input  logic          bready,
  input  axiPkg::axiArT ar,
  output logic          arready,
  output axiPkg::axiRT  r,
  input  logic          rready
);
  import aluPkg::*;

  aluReqT  launch;
  logic    launchValid;
  aluReqT  laneReq [NumLanes];
  logic [NumLanes-1:0] laneReqValid;
  aluRespT laneResp [NumLanes];
  logic [NumLanes-1:0] laneRespValid;
  logic [$clog2(NumSlots)-1:0] slotClear;
  logic    slotClearValid;
  logic [$clog2(NumSlots)-1:0] slotIndex;
  logic [31:0] slotResult;
  aluFlagsT slotFlags;

  axiLiteRegs #(.NumSlots(NumSlots)) uRegs (
    .clk, .rstN,
    .aw, .awready, .w, .wready, .b, .bready,
    .ar, .arready, .r, .rready,
    .launch, .launchValid,
    .slotIndex, .slotResult, .slotFlags
  );

  jobDispatch #(.NumLanes(NumLanes), .NumSlots(NumSlots)) uDispatch (
    .clk, .rstN,
    .launch, .launchValid,
    .laneReq, .laneValid(laneReqValid),
    .slotClear, .slotClearValid
  );

  for (genvar k = 0; k < NumLanes; k++) begin : gLane
    aluLane uLane (
      .clk, .rstN,
      .req(laneReq[k]), .reqValid(laneReqValid[k]),
      .resp(laneResp[k]), .respValid(laneRespValid[k])
    );
  end

  resultCollect #(.NumLanes(NumLanes), .NumSlots(NumSlots)) uCollect (
    .clk, .rstN,
    .laneResp, .laneValid(laneRespValid),
    .slotClear, .slotClearValid,
    .slotIndex, .slotResult, .slotFlags
  );

endmodule

`default_nettype wire

//--- source/aluLane.sv
`default_nettype none

module aluLane (
  input  logic            clk,
  input  logic            rstN,
  input  aluPkg::aluReqT  req,
  input  logic            reqValid,
  output aluPkg::aluRespT resp,
  output logic            respValid
);
  import aluPkg::*;

  typedef enum logic [2:0] {SelAdd, SelXor, SelSlt, SelAnd, SelOr} laneSelE;

  laneSelE          outSel;
  logic             invertA;
  logic             invertB;
  logic             carryIn;      // also flips B into the adder, so it means subtract
  logic             enableFlags;
  logic [DataW-1:0] flipA;
  logic [DataW-1:0] flipB;
  logic [DataW-1:0] addB;
  logic [DataW:0]   sum;
  logic             overflow;
  logic             sltBit;
  logic [DataW-1:0] result;

  // control table, NAND and NOR reuse the OR and AND paths with both inputs inverted
  always_comb begin
    outSel = SelAdd;
    invertA = 1'b0;
    invertB = 1'b0;
    carryIn = 1'b0;
    enableFlags = 1'b0;
    unique case (req.opcode)
      OpAdd:  enableFlags = 1'b1;
      OpSub: begin
        carryIn = 1'b1;
        enableFlags = 1'b1;
      end
      OpXor:  outSel = SelXor;
      OpSlt: begin
        outSel = SelSlt;
        carryIn = 1'b1;
      end
      OpAnd:  outSel = SelAnd;
      OpNand: begin
        outSel = SelOr;
        invertA = 1'b1;
        invertB = 1'b1;
      end
      OpNor: begin
        outSel = SelAnd;
        invertA = 1'b1;
        invertB = 1'b1;
      end
      OpOr:   outSel = SelOr;
    endcase
  end

  assign flipA = req.operandA ^ {DataW{invertA}};
  assign flipB = req.operandB ^ {DataW{invertB}};

  assign addB = req.operandB ^ {DataW{carryIn}};
  assign sum = {1'b0, req.operandA} + {1'b0, addB} + (DataW + 1)'(carryIn);
  // same input signs but a different result sign
  assign overflow = (req.operandA[DataW-1] == addB[DataW-1]) &&
                    (sum[DataW-1] != req.operandA[DataW-1]);
  assign sltBit = sum[DataW-1] ^ overflow;

  always_comb begin
    unique case (outSel)
      SelXor:  result = flipA ^ flipB;
      SelSlt:  result = {{(DataW-1){1'b0}}, sltBit};
      SelAnd:  result = flipA & flipB;
      SelOr:   result = flipA | flipB;
      default: result = sum[DataW-1:0];
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      respValid <= 1'b0;
    end else begin
      respValid <= reqValid;
    end
  end

  always_ff @(posedge clk) begin
    resp.result         <= result;
    resp.flags.valid    <= 1'b1;
    resp.flags.overflow <= enableFlags & overflow;
    resp.flags.zero     <= (result == '0);
    resp.flags.carryout <= enableFlags & sum[DataW];
    resp.tag            <= req.tag;
  end

endmodule

`default_nettype wire

//--- source/aluPkg.sv
`default_nettype none

package aluPkg;

  // slot count the design is built for by default; the tag field is sized for it
  localparam int DefaultSlots = 16;
  localparam int TagW = $clog2(DefaultSlots);
  localparam int DataW = 32;

  typedef enum logic [2:0] {
    OpAdd  = 3'd0,
    OpSub  = 3'd1,
    OpXor  = 3'd2,
    OpSlt  = 3'd3,
    OpAnd  = 3'd4,
    OpNand = 3'd5,
    OpNor  = 3'd6,
    OpOr   = 3'd7
  } aluOpE;

  typedef struct packed {
    logic valid;     // slot holds a finished result
    logic overflow;  // signed overflow, add/sub only
    logic zero;
    logic carryout;  // carry out of bit 31, add/sub only
  } aluFlagsT;

  typedef struct packed {
    aluOpE             opcode;
    logic [DataW-1:0]  operandA;
    logic [DataW-1:0]  operandB;
    logic [TagW-1:0]   tag;
  } aluReqT;

  typedef struct packed {
    logic [DataW-1:0]  result;
    aluFlagsT          flags;
    logic [TagW-1:0]   tag;
  } aluRespT;

endpackage

`default_nettype wire

//--- source/axiLiteRegs.sv
`default_nettype none

module axiLiteRegs #(
  parameter int NumSlots = 16
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  axiPkg::axiAwT               aw,
  output logic                        awready,
  input  axiPkg::axiWT                w,
  output logic                        wready,
  output axiPkg::axiBT                b,
  input  logic                        bready,
  input  axiPkg::axiArT               ar,
  output logic                        arready,
  output axiPkg::axiRT                r,
  input  logic                        rready,
  output aluPkg::aluReqT              launch,
  output logic                        launchValid,
  output logic [$clog2(NumSlots)-1:0] slotIndex,
  input  logic [31:0]                 slotResult,
  input  aluPkg::aluFlagsT            slotFlags
);
  import axiPkg::*;
  import aluPkg::*;

  localparam int IdxW = $clog2(NumSlots);
  localparam logic [AddrW-1:0] SlotEnd = SlotBase + AddrW'(8 * NumSlots);

  logic [31:0] opA;
  logic [31:0] opB;
  logic        bValid;
  axiRespE     bResp;
  logic        rValid;
  axiRespE     rResp;
  logic [31:0] rData;
  logic        wrFire;
  logic        rdFire;
  logic        wrOk;
  logic [AddrW-1:0] rdOffset;
  logic        rdIsSlot;
  logic [31:0] rdData;
  axiRespE     rdResp;

  function automatic logic [31:0] applyStrb(logic [31:0] old, logic [31:0] data,
                                            logic [3:0] strb);
    logic [31:0] merged;
    merged = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) merged[8*i +: 8] = data[8*i +: 8];
    end
    return merged;
  endfunction

  // AW and W are taken together, and only while no B response is waiting
  assign awready = !bValid && w.valid;
  assign wready  = !bValid && aw.valid;
  assign wrFire  = aw.valid && w.valid && !bValid;
  assign arready = !rValid;
  assign rdFire  = ar.valid && !rValid;

  assign wrOk = (aw.addr == OperandAAddr) || (aw.addr == OperandBAddr) ||
                (aw.addr == CommandAddr);

  assign launchValid = wrFire && (aw.addr == CommandAddr);
  assign launch = '{opcode:   aluOpE'(w.data[2:0]),
                    operandA: opA,
                    operandB: opB,
                    tag:      w.data[CmdTagLsb +: TagW]};

  assign rdOffset = ar.addr - SlotBase;
  assign rdIsSlot = (ar.addr >= SlotBase) && (ar.addr < SlotEnd) && (ar.addr[1:0] == 2'b00);
  assign slotIndex = rdOffset[IdxW+2:3];

  always_comb begin
    rdData = '0;
    rdResp = AxiOkay;
    if (ar.addr == OperandAAddr) rdData = opA;
    else if (ar.addr == OperandBAddr) rdData = opB;
    else if (rdIsSlot) rdData = ar.addr[2] ? 32'(slotFlags) : slotResult;
    else rdResp = AxiSlvErr;  // command word included, it cannot be read
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opA <= '0;
      opB <= '0;
      bValid <= 1'b0;
      rValid <= 1'b0;
    end else begin
      if (wrFire && aw.addr == OperandAAddr) opA <= applyStrb(opA, w.data, w.strb);
      if (wrFire && aw.addr == OperandBAddr) opB <= applyStrb(opB, w.data, w.strb);
      if (wrFire) bValid <= 1'b1;
      else if (bready) bValid <= 1'b0;
      if (rdFire) rValid <= 1'b1;
      else if (rready) rValid <= 1'b0;
    end
  end

  // response payload, only sampled on acceptance
  always_ff @(posedge clk) begin
    if (wrFire) bResp <= wrOk ? AxiOkay : AxiSlvErr;
    if (rdFire) begin
      rData <= rdData;
      rResp <= rdResp;
    end
  end

  assign b = '{resp: bResp, valid: bValid};
  assign r = '{data: rData, resp: rResp, valid: rValid};

endmodule

`default_nettype wire

//--- source/axiPkg.sv
`default_nettype none

package axiPkg;

  localparam int AddrW = 32;
  localparam int DataW = 32;

  typedef enum logic [1:0] {
    AxiOkay   = 2'b00,
    AxiSlvErr = 2'b10
  } axiRespE;

  typedef struct packed {
    logic [AddrW-1:0] addr;
    logic             valid;
  } axiAwT;

  typedef struct packed {
    logic [AddrW-1:0] addr;
    logic             valid;
  } axiArT;

  typedef struct packed {
    logic [DataW-1:0]   data;
    logic [DataW/8-1:0] strb;
    logic               valid;
  } axiWT;

  typedef struct packed {
    axiRespE resp;
    logic    valid;
  } axiBT;

  typedef struct packed {
    logic [DataW-1:0] data;
    axiRespE          resp;
    logic             valid;
  } axiRT;

  // register map
  localparam logic [AddrW-1:0] OperandAAddr = 32'h00;
  localparam logic [AddrW-1:0] OperandBAddr = 32'h04;
  localparam logic [AddrW-1:0] CommandAddr  = 32'h08;  // write only, launches a job
  localparam logic [AddrW-1:0] SlotBase     = 32'h40;  // result at +8t, flags at +8t+4
  localparam int CmdTagLsb = 8;                         // opcode sits at bits 2:0

endpackage

`default_nettype wire

//--- source/jobDispatch.sv
`default_nettype none

module jobDispatch #(
  parameter int NumLanes = 4,
  parameter int NumSlots = 16
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  aluPkg::aluReqT              launch,
  input  logic                        launchValid,
  output aluPkg::aluReqT              laneReq [NumLanes],
  output logic [NumLanes-1:0]         laneValid,
  output logic [$clog2(NumSlots)-1:0] slotClear,
  output logic                        slotClearValid
);

  localparam int PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;
  localparam int IdxW = $clog2(NumSlots);

  logic [PtrW-1:0] ptr;  // next lane to receive a job

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptr <= '0;
      laneValid <= '0;
      slotClearValid <= 1'b0;
    end else begin
      for (int k = 0; k < NumLanes; k++) begin
        laneValid[k] <= launchValid && (ptr == PtrW'(k));
      end
      slotClearValid <= launchValid;
      if (launchValid) begin
        ptr <= (ptr == PtrW'(NumLanes - 1)) ? '0 : ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NumLanes; k++) begin
      if (launchValid && (ptr == PtrW'(k))) laneReq[k] <= launch;
    end
    slotClear <= launch.tag[IdxW-1:0];  // upper tag bits drop when fewer slots
  end

endmodule

`default_nettype wire

//--- source/resultCollect.sv
`default_nettype none

module resultCollect #(
  parameter int NumLanes = 4,
  parameter int NumSlots = 16
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  aluPkg::aluRespT             laneResp [NumLanes],
  input  logic [NumLanes-1:0]         laneValid,
  input  logic [$clog2(NumSlots)-1:0] slotClear,
  input  logic                        slotClearValid,
  input  logic [$clog2(NumSlots)-1:0] slotIndex,
  output logic [31:0]                 slotResult,
  output aluPkg::aluFlagsT            slotFlags
);
  import aluPkg::*;

  localparam int IdxW = $clog2(NumSlots);

  logic [DataW-1:0] slotRes [NumSlots];
  aluFlagsT         slotFlg [NumSlots];  // valid field here is shadowed by slotValid
  logic [NumSlots-1:0] slotValid;

  // clear first so a lane write in the same cycle wins
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slotValid <= '0;
    end else begin
      if (slotClearValid) slotValid[slotClear] <= 1'b0;
      for (int k = 0; k < NumLanes; k++) begin
        if (laneValid[k]) slotValid[laneResp[k].tag[IdxW-1:0]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NumLanes; k++) begin
      if (laneValid[k]) begin
        slotRes[laneResp[k].tag[IdxW-1:0]] <= laneResp[k].result;
        slotFlg[laneResp[k].tag[IdxW-1:0]] <= laneResp[k].flags;
      end
    end
  end

  // asynchronous read port
  assign slotResult = slotRes[slotIndex];

  always_comb begin
    slotFlags = slotFlg[slotIndex];
    slotFlags.valid = slotValid[slotIndex];
  end

endmodule

`default_nettype wire
